// ==== src/cache_pkg.sv ====
// Cache request definitions

package cache_pkg;

  // Data word width, also the word address width
  localparam int word_width_c = 32;

  // Client and bank request opcode
  typedef enum logic {
    LOAD  = 1'b0
    ,STORE = 1'b1
  } cache_op_e;

endpackage

// ==== src/dma_pkg.sv ====
// Memory side DMA definitions

package dma_pkg;

  // Bank to memory command opcode
  typedef enum logic {
    READ_BLOCK = 1'b0  // Stream block_words_p words back
    ,WRITE_WORD = 1'b1 // Single word write-through
  } dma_op_e;

endpackage

// ==== src/cache_bank.sv ====
// Direct-mapped write-through cache bank

`timescale 1ns/10ps

module cache_bank #(
  parameter int sets_p = 16
  ,parameter int block_words_p = 4
) (
  input clock_i
  ,input reset_i

  ,input v_i
  ,input cache_pkg::cache_op_e op_i
  ,input [cache_pkg::word_width_c-1:0] addr_i
  ,input [cache_pkg::word_width_c-1:0] data_i
  ,output logic ready_o

  ,output logic v_o
  ,output logic [cache_pkg::word_width_c-1:0] data_o
  ,input yumi_i

  ,output logic dma_v_o
  ,output dma_pkg::dma_op_e dma_op_o
  ,output logic [cache_pkg::word_width_c-1:0] dma_addr_o
  ,output logic [cache_pkg::word_width_c-1:0] dma_wdata_o
  ,input dma_yumi_i

  ,input fill_v_i
  ,input [cache_pkg::word_width_c-1:0] fill_data_i
  ,output logic fill_ready_o
);

  localparam int off_w_lp = $clog2(block_words_p);
  localparam int idx_w_lp = $clog2(sets_p);
  localparam int tag_lo_lp = off_w_lp + 1 + idx_w_lp; // Offset, bank bit, index
  localparam int tag_w_lp = cache_pkg::word_width_c - tag_lo_lp;

  typedef enum logic [2:0] {
    IDLE
    ,LOOKUP
    ,FILL_REQ
    ,FILL
    ,STORE_REQ
    ,RESP
  } state_e;

  state_e state_r;
  logic up_r;
  logic [sets_p-1:0] valid_r;
  logic [off_w_lp-1:0] fill_cnt_r;

  cache_pkg::cache_op_e op_r;
  logic [cache_pkg::word_width_c-1:0] addr_r;
  logic [cache_pkg::word_width_c-1:0] wdata_r;
  logic [cache_pkg::word_width_c-1:0] resp_data_r;

  logic [tag_w_lp-1:0] tag_r [sets_p];
  logic [cache_pkg::word_width_c-1:0] data_r [sets_p][block_words_p];

  logic [off_w_lp-1:0] off;
  logic [idx_w_lp-1:0] idx;
  logic [tag_w_lp-1:0] tag;
  logic hit;
  logic fill_last;

  assign off = addr_r[off_w_lp-1:0];
  assign idx = addr_r[off_w_lp+1 +: idx_w_lp];
  assign tag = addr_r[cache_pkg::word_width_c-1:tag_lo_lp];
  assign hit = valid_r[idx] & (tag_r[idx] == tag);
  assign fill_last = fill_v_i & (fill_cnt_r == off_w_lp'(block_words_p - 1));

  // ##############################
  // Control FSM
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      up_r <= 1'b0;
      valid_r <= '0;
      fill_cnt_r <= '0;
    end else begin
      up_r <= 1'b1;
      case (state_r)
        IDLE: if (v_i & ready_o) state_r <= LOOKUP;
        LOOKUP: begin
          if (op_r == cache_pkg::STORE) state_r <= STORE_REQ;
          else if (hit) state_r <= RESP;
          else state_r <= FILL_REQ;
        end
        FILL_REQ: begin
          if (dma_yumi_i) begin
            state_r <= FILL;
            fill_cnt_r <= '0;
          end
        end
        FILL: begin
          if (fill_v_i) fill_cnt_r <= fill_cnt_r + 1'b1;
          if (fill_last) begin
            state_r <= RESP;
            valid_r[idx] <= 1'b1; // Tag is written in the same cycle
          end
        end
        STORE_REQ: if (dma_yumi_i) state_r <= RESP;
        RESP: if (yumi_i) state_r <= IDLE;
        default: state_r <= IDLE;
      endcase
    end
  end

  // ##############################
  // Request, arrays and response word
  always_ff @(posedge clock_i) begin
    if (v_i & ready_o) begin
      op_r <= op_i;
      addr_r <= addr_i;
      wdata_r <= data_i;
    end
    if (state_r == LOOKUP) begin
      resp_data_r <= (op_r == cache_pkg::STORE) ? '0 : data_r[idx][off];
      if ((op_r == cache_pkg::STORE) & hit) data_r[idx][off] <= wdata_r; // No allocate on miss
    end
    if ((state_r == FILL) & fill_v_i) begin
      data_r[idx][fill_cnt_r] <= fill_data_i;
      if (fill_cnt_r == off) resp_data_r <= fill_data_i; // Critical word
      if (fill_last) tag_r[idx] <= tag;
    end
  end

  assign ready_o = up_r & (state_r == IDLE);
  assign v_o = (state_r == RESP);
  assign data_o = resp_data_r;

  assign dma_v_o = (state_r == FILL_REQ) | (state_r == STORE_REQ);
  assign dma_op_o = (state_r == STORE_REQ) ? dma_pkg::WRITE_WORD : dma_pkg::READ_BLOCK;
  assign dma_addr_o = (state_r == STORE_REQ)
                    ? addr_r
                    : {addr_r[cache_pkg::word_width_c-1:off_w_lp], {off_w_lp{1'b0}}};
  assign dma_wdata_o = wdata_r;
  assign fill_ready_o = (state_r == FILL);

endmodule

// ==== src/bank_router.sv ====
// In-order request router for two banks

`timescale 1ns/10ps

module bank_router #(
  parameter int block_words_p = 4
) (
  input clock_i
  ,input reset_i

  ,input v_i
  ,input cache_pkg::cache_op_e op_i
  ,input [cache_pkg::word_width_c-1:0] addr_i
  ,input [cache_pkg::word_width_c-1:0] data_i
  ,output logic ready_o

  ,output logic v_o
  ,output logic [cache_pkg::word_width_c-1:0] data_o
  ,input yumi_i

  ,output logic bank_v_0_o
  ,output cache_pkg::cache_op_e bank_op_0_o
  ,output logic [cache_pkg::word_width_c-1:0] bank_addr_0_o
  ,output logic [cache_pkg::word_width_c-1:0] bank_data_0_o
  ,input bank_ready_0_i
  ,input bank_resp_v_0_i
  ,input [cache_pkg::word_width_c-1:0] bank_resp_data_0_i
  ,output logic bank_resp_yumi_0_o

  ,output logic bank_v_1_o
  ,output cache_pkg::cache_op_e bank_op_1_o
  ,output logic [cache_pkg::word_width_c-1:0] bank_addr_1_o
  ,output logic [cache_pkg::word_width_c-1:0] bank_data_1_o
  ,input bank_ready_1_i
  ,input bank_resp_v_1_i
  ,input [cache_pkg::word_width_c-1:0] bank_resp_data_1_i
  ,output logic bank_resp_yumi_1_o
);

  localparam int sel_bit_lp = $clog2(block_words_p);

  logic up_r;
  logic req_v_r;
  logic req_bank_r;
  cache_pkg::cache_op_e req_op_r;
  logic [cache_pkg::word_width_c-1:0] req_addr_r;
  logic [cache_pkg::word_width_c-1:0] req_data_r;

  logic q_r [4]; // Bank number per request in flight
  logic [1:0] q_wr_r;
  logic [1:0] q_rd_r;
  logic [2:0] q_cnt_r;

  logic resp_v_r;
  logic [cache_pkg::word_width_c-1:0] resp_data_r;

  logic req_go;
  logic accept;
  logic head;
  logic resp_free;
  logic pop;

  assign req_go = req_v_r & (req_bank_r ? bank_ready_1_i : bank_ready_0_i);
  assign ready_o = up_r & (q_cnt_r != 3'd4) & (~req_v_r | req_go);
  assign accept = v_i & ready_o;

  assign head = q_r[q_rd_r];
  assign resp_free = ~resp_v_r | yumi_i;
  assign bank_resp_yumi_0_o = (q_cnt_r != 3'd0) & ~head & bank_resp_v_0_i & resp_free;
  assign bank_resp_yumi_1_o = (q_cnt_r != 3'd0) & head & bank_resp_v_1_i & resp_free;
  assign pop = bank_resp_yumi_0_o | bank_resp_yumi_1_o;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      up_r <= 1'b0;
      req_v_r <= 1'b0;
      q_wr_r <= '0;
      q_rd_r <= '0;
      q_cnt_r <= '0;
      resp_v_r <= 1'b0;
    end else begin
      up_r <= 1'b1;
      if (accept) req_v_r <= 1'b1;
      else if (req_go) req_v_r <= 1'b0;
      q_wr_r <= q_wr_r + {1'b0, accept};
      q_rd_r <= q_rd_r + {1'b0, pop};
      q_cnt_r <= q_cnt_r + {2'b0, accept} - {2'b0, pop};
      if (pop) resp_v_r <= 1'b1;
      else if (yumi_i) resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clock_i) begin
    if (accept) begin
      req_bank_r <= addr_i[sel_bit_lp];
      req_op_r <= op_i;
      req_addr_r <= addr_i;
      req_data_r <= data_i;
      q_r[q_wr_r] <= addr_i[sel_bit_lp];
    end
    if (pop) resp_data_r <= head ? bank_resp_data_1_i : bank_resp_data_0_i;
  end

  assign bank_v_0_o = req_v_r & ~req_bank_r;
  assign bank_v_1_o = req_v_r & req_bank_r;
  assign bank_op_0_o = req_op_r;
  assign bank_op_1_o = req_op_r;
  assign bank_addr_0_o = req_addr_r;
  assign bank_addr_1_o = req_addr_r;
  assign bank_data_0_o = req_data_r;
  assign bank_data_1_o = req_data_r;

  assign v_o = resp_v_r;
  assign data_o = resp_data_r;

endmodule

// ==== src/dram_arbiter.sv ====
// Round-robin DMA arbiter

`timescale 1ns/10ps

module dram_arbiter #(
  parameter int block_words_p = 4
) (
  input clock_i
  ,input reset_i

  ,input dma_v_0_i
  ,input dma_pkg::dma_op_e dma_op_0_i
  ,input [cache_pkg::word_width_c-1:0] dma_addr_0_i
  ,input [cache_pkg::word_width_c-1:0] dma_wdata_0_i
  ,output logic dma_yumi_0_o
  ,output logic fill_v_0_o
  ,output logic [cache_pkg::word_width_c-1:0] fill_data_0_o
  ,input fill_ready_0_i

  ,input dma_v_1_i
  ,input dma_pkg::dma_op_e dma_op_1_i
  ,input [cache_pkg::word_width_c-1:0] dma_addr_1_i
  ,input [cache_pkg::word_width_c-1:0] dma_wdata_1_i
  ,output logic dma_yumi_1_o
  ,output logic fill_v_1_o
  ,output logic [cache_pkg::word_width_c-1:0] fill_data_1_o
  ,input fill_ready_1_i

  ,output logic mem_v_o
  ,output dma_pkg::dma_op_e mem_op_o
  ,output logic [cache_pkg::word_width_c-1:0] mem_addr_o
  ,output logic [cache_pkg::word_width_c-1:0] mem_wdata_o
  ,input mem_ready_i
  ,input mem_rdata_v_i
  ,input [cache_pkg::word_width_c-1:0] mem_rdata_i
);

  localparam int cnt_w_lp = $clog2(block_words_p);

  typedef enum logic [1:0] {
    ARB_IDLE
    ,ARB_CMD
    ,ARB_READ
  } state_e;

  state_e state_r;
  logic grant_r; // Granted bank
  logic prio_r;  // Bank preferred at the next grant
  logic [cnt_w_lp-1:0] cnt_r;

  logic pick;
  logic word;

  assign pick = dma_v_1_i & (prio_r | ~dma_v_0_i);
  assign word = mem_rdata_v_i & (grant_r ? fill_ready_1_i : fill_ready_0_i);

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_r <= ARB_IDLE;
      grant_r <= 1'b0;
      prio_r <= 1'b0;
      cnt_r <= '0;
    end else begin
      case (state_r)
        ARB_IDLE: begin
          if (dma_v_0_i | dma_v_1_i) begin
            grant_r <= pick;
            prio_r <= ~pick;
            state_r <= ARB_CMD;
          end
        end
        ARB_CMD: begin
          if (mem_v_o & mem_ready_i) begin
            state_r <= (mem_op_o == dma_pkg::WRITE_WORD) ? ARB_IDLE : ARB_READ;
            cnt_r <= '0;
          end
        end
        ARB_READ: begin
          if (word) begin
            cnt_r <= cnt_r + 1'b1;
            if (cnt_r == cnt_w_lp'(block_words_p - 1)) state_r <= ARB_IDLE;
          end
        end
        default: state_r <= ARB_IDLE;
      endcase
    end
  end

  assign mem_v_o = (state_r == ARB_CMD) & (grant_r ? dma_v_1_i : dma_v_0_i);
  assign mem_op_o = grant_r ? dma_op_1_i : dma_op_0_i;
  assign mem_addr_o = grant_r ? dma_addr_1_i : dma_addr_0_i;
  assign mem_wdata_o = grant_r ? dma_wdata_1_i : dma_wdata_0_i;

  assign dma_yumi_0_o = ~grant_r & mem_v_o & mem_ready_i;
  assign dma_yumi_1_o = grant_r & mem_v_o & mem_ready_i;

  assign fill_v_0_o = (state_r == ARB_READ) & ~grant_r & mem_rdata_v_i;
  assign fill_v_1_o = (state_r == ARB_READ) & grant_r & mem_rdata_v_i;
  assign fill_data_0_o = mem_rdata_i;
  assign fill_data_1_o = mem_rdata_i;

endmodule

// ==== src/mock_dram.sv ====
// Mock word memory with block reads

`timescale 1ns/10ps

module mock_dram #(
  parameter int block_words_p = 4
  ,parameter int mem_words_p = 1024
) (
  input clock_i
  ,input reset_i

  ,input mem_v_i
  ,input dma_pkg::dma_op_e mem_op_i
  ,input [cache_pkg::word_width_c-1:0] mem_addr_i
  ,input [cache_pkg::word_width_c-1:0] mem_wdata_i
  ,output logic mem_ready_o

  ,output logic mem_rdata_v_o
  ,output logic [cache_pkg::word_width_c-1:0] mem_rdata_o
);

  localparam int aw_lp = $clog2(mem_words_p);
  localparam int cnt_w_lp = $clog2(block_words_p);

  typedef enum logic [1:0] {
    DRAM_IDLE
    ,DRAM_WAIT
    ,DRAM_STREAM
  } state_e;

  state_e state_r;
  logic up_r;
  logic [cnt_w_lp-1:0] cnt_r;
  logic rdata_v_r;
  logic [aw_lp-1:0] base_r;
  logic [cache_pkg::word_width_c-1:0] rdata_r;
  logic [cache_pkg::word_width_c-1:0] mem_r [mem_words_p];

  logic accept;

  // Word a holds ~a
  initial begin
    for (int i = 0; i < mem_words_p; i++) mem_r[i] = ~(cache_pkg::word_width_c)'(i);
  end

  assign mem_ready_o = up_r & (state_r == DRAM_IDLE);
  assign accept = mem_v_i & mem_ready_o;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_r <= DRAM_IDLE;
      up_r <= 1'b0;
      cnt_r <= '0;
      rdata_v_r <= 1'b0;
    end else begin
      up_r <= 1'b1;
      rdata_v_r <= (state_r == DRAM_STREAM);
      case (state_r)
        DRAM_IDLE: begin
          if (accept & (mem_op_i == dma_pkg::READ_BLOCK)) begin
            state_r <= DRAM_WAIT;
            cnt_r <= '0;
          end
        end
        DRAM_WAIT: state_r <= DRAM_STREAM;
        DRAM_STREAM: begin
          cnt_r <= cnt_r + 1'b1;
          if (cnt_r == cnt_w_lp'(block_words_p - 1)) state_r <= DRAM_IDLE;
        end
        default: state_r <= DRAM_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock_i) begin
    if (accept) base_r <= mem_addr_i[aw_lp-1:0]; // Wraps modulo memory size
    if (accept & (mem_op_i == dma_pkg::WRITE_WORD)) mem_r[mem_addr_i[aw_lp-1:0]] <= mem_wdata_i;
    if (state_r == DRAM_STREAM) rdata_r <= mem_r[base_r + aw_lp'(cnt_r)];
  end

  assign mem_rdata_v_o = rdata_v_r;
  assign mem_rdata_o = rdata_r;

endmodule

// ==== src/test_node_client.sv ====
// Two-bank cache test node

`timescale 1ns/10ps

module test_node_client #(
  parameter int sets_p = 16
  ,parameter int block_words_p = 4
  ,parameter int mem_words_p = 1024
) (
  input clock_i
  ,input reset_i

  ,input v_i
  ,input cache_pkg::cache_op_e op_i
  ,input [cache_pkg::word_width_c-1:0] addr_i
  ,input [cache_pkg::word_width_c-1:0] data_i
  ,output logic ready_o

  ,output logic v_o
  ,output logic [cache_pkg::word_width_c-1:0] data_o
  ,input yumi_i
);

  // ##############################
  // Router to banks
  logic bank_v_0, bank_ready_0, bank_resp_v_0, bank_resp_yumi_0;
  logic bank_v_1, bank_ready_1, bank_resp_v_1, bank_resp_yumi_1;
  cache_pkg::cache_op_e bank_op_0, bank_op_1;
  logic [cache_pkg::word_width_c-1:0] bank_addr_0, bank_data_0, bank_resp_data_0;
  logic [cache_pkg::word_width_c-1:0] bank_addr_1, bank_data_1, bank_resp_data_1;

  // ##############################
  // Banks to arbiter to memory
  logic dma_v_0, dma_yumi_0, fill_v_0, fill_ready_0;
  logic dma_v_1, dma_yumi_1, fill_v_1, fill_ready_1;
  dma_pkg::dma_op_e dma_op_0, dma_op_1, mem_op;
  logic [cache_pkg::word_width_c-1:0] dma_addr_0, dma_wdata_0, fill_data_0;
  logic [cache_pkg::word_width_c-1:0] dma_addr_1, dma_wdata_1, fill_data_1;
  logic mem_v, mem_ready, mem_rdata_v;
  logic [cache_pkg::word_width_c-1:0] mem_addr, mem_wdata, mem_rdata;

  bank_router #(.block_words_p(block_words_p)) router (
    .clock_i(clock_i), .reset_i(reset_i)
    ,.v_i(v_i), .op_i(op_i), .addr_i(addr_i), .data_i(data_i), .ready_o(ready_o)
    ,.v_o(v_o), .data_o(data_o), .yumi_i(yumi_i)
    ,.bank_v_0_o(bank_v_0), .bank_op_0_o(bank_op_0), .bank_addr_0_o(bank_addr_0)
    ,.bank_data_0_o(bank_data_0), .bank_ready_0_i(bank_ready_0)
    ,.bank_resp_v_0_i(bank_resp_v_0), .bank_resp_data_0_i(bank_resp_data_0)
    ,.bank_resp_yumi_0_o(bank_resp_yumi_0)
    ,.bank_v_1_o(bank_v_1), .bank_op_1_o(bank_op_1), .bank_addr_1_o(bank_addr_1)
    ,.bank_data_1_o(bank_data_1), .bank_ready_1_i(bank_ready_1)
    ,.bank_resp_v_1_i(bank_resp_v_1), .bank_resp_data_1_i(bank_resp_data_1)
    ,.bank_resp_yumi_1_o(bank_resp_yumi_1)
  );

  cache_bank #(.sets_p(sets_p), .block_words_p(block_words_p)) bank_0 (
    .clock_i(clock_i), .reset_i(reset_i)
    ,.v_i(bank_v_0), .op_i(bank_op_0), .addr_i(bank_addr_0), .data_i(bank_data_0)
    ,.ready_o(bank_ready_0)
    ,.v_o(bank_resp_v_0), .data_o(bank_resp_data_0), .yumi_i(bank_resp_yumi_0)
    ,.dma_v_o(dma_v_0), .dma_op_o(dma_op_0), .dma_addr_o(dma_addr_0)
    ,.dma_wdata_o(dma_wdata_0), .dma_yumi_i(dma_yumi_0)
    ,.fill_v_i(fill_v_0), .fill_data_i(fill_data_0), .fill_ready_o(fill_ready_0)
  );

  cache_bank #(.sets_p(sets_p), .block_words_p(block_words_p)) bank_1 (
    .clock_i(clock_i), .reset_i(reset_i)
    ,.v_i(bank_v_1), .op_i(bank_op_1), .addr_i(bank_addr_1), .data_i(bank_data_1)
    ,.ready_o(bank_ready_1)
    ,.v_o(bank_resp_v_1), .data_o(bank_resp_data_1), .yumi_i(bank_resp_yumi_1)
    ,.dma_v_o(dma_v_1), .dma_op_o(dma_op_1), .dma_addr_o(dma_addr_1)
    ,.dma_wdata_o(dma_wdata_1), .dma_yumi_i(dma_yumi_1)
    ,.fill_v_i(fill_v_1), .fill_data_i(fill_data_1), .fill_ready_o(fill_ready_1)
  );

  dram_arbiter #(.block_words_p(block_words_p)) arbiter (
    .clock_i(clock_i), .reset_i(reset_i)
    ,.dma_v_0_i(dma_v_0), .dma_op_0_i(dma_op_0), .dma_addr_0_i(dma_addr_0)
    ,.dma_wdata_0_i(dma_wdata_0), .dma_yumi_0_o(dma_yumi_0)
    ,.fill_v_0_o(fill_v_0), .fill_data_0_o(fill_data_0), .fill_ready_0_i(fill_ready_0)
    ,.dma_v_1_i(dma_v_1), .dma_op_1_i(dma_op_1), .dma_addr_1_i(dma_addr_1)
    ,.dma_wdata_1_i(dma_wdata_1), .dma_yumi_1_o(dma_yumi_1)
    ,.fill_v_1_o(fill_v_1), .fill_data_1_o(fill_data_1), .fill_ready_1_i(fill_ready_1)
    ,.mem_v_o(mem_v), .mem_op_o(mem_op), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata)
    ,.mem_ready_i(mem_ready), .mem_rdata_v_i(mem_rdata_v), .mem_rdata_i(mem_rdata)
  );

  mock_dram #(.block_words_p(block_words_p), .mem_words_p(mem_words_p)) dram (
    .clock_i(clock_i), .reset_i(reset_i)
    ,.mem_v_i(mem_v), .mem_op_i(mem_op), .mem_addr_i(mem_addr), .mem_wdata_i(mem_wdata)
    ,.mem_ready_o(mem_ready), .mem_rdata_v_o(mem_rdata_v), .mem_rdata_o(mem_rdata)
  );

endmodule

// ==== verif/tb_test_node_client.sv ====
// Testbench for the two-bank cache test node

`timescale 1ns/10ps

module tb_test_node_client;

  localparam int w_lp = cache_pkg::word_width_c;
  localparam int sets_lp = 16;
  localparam int block_words_lp = 4;
  localparam int mem_words_lp = 1024;
  localparam int maw_lp = $clog2(mem_words_lp);
  localparam int num_tests_lp = 24;
  localparam int timeout_lp = num_tests_lp * 40 + 200;

  logic clock_i = 1'b0;
  logic reset_i;
  logic v_i;
  cache_pkg::cache_op_e op_i;
  logic [w_lp-1:0] addr_i;
  logic [w_lp-1:0] data_i;
  logic ready_o;
  logic v_o;
  logic [w_lp-1:0] data_o;
  logic yumi_i;

  // ##############################
  // Stimulus table with one entry per test
  string name_q [$];
  cache_pkg::cache_op_e op_q [$];
  logic [w_lp-1:0] addr_q [$];
  logic [w_lp-1:0] wdata_q [$];
  logic [w_lp-1:0] exp_q [$];

  logic [w_lp-1:0] model_mem [mem_words_lp]; // Reference copy of the mock DRAM
  integer seed = 32'h4e7afb37;
  int cycle_cnt = 0;
  int resp_cnt = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;
  int other_errs = 0;

  test_node_client #(
    .sets_p(sets_lp)
    ,.block_words_p(block_words_lp)
    ,.mem_words_p(mem_words_lp)
  ) DUT (
    .clock_i(clock_i), .reset_i(reset_i)
    ,.v_i(v_i), .op_i(op_i), .addr_i(addr_i), .data_i(data_i), .ready_o(ready_o)
    ,.v_o(v_o), .data_o(data_o), .yumi_i(yumi_i)
  );

  always #5 clock_i = ~clock_i;

  always @(posedge clock_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_lp) begin
      $display("Timeout after %0d cycles with %0d of %0d responses received",
               cycle_cnt, resp_cnt, num_tests_lp);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic add_entry(input string name, input cache_pkg::cache_op_e op,
                           input logic [w_lp-1:0] addr, input logic [w_lp-1:0] wdata,
                           input logic [w_lp-1:0] exp);
    name_q.push_back(name);
    op_q.push_back(op);
    addr_q.push_back(addr);
    wdata_q.push_back(wdata);
    exp_q.push_back(exp);
  endtask

  task automatic compare_word(input string name, input logic [w_lp-1:0] exp,
                              input logic [w_lp-1:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      fail_cnt++;
    end else begin
      $display("[PASS] %s data %h", name, act);
      pass_cnt++;
    end
  endtask

  // ##############################
  // Requests issued back to back
  task automatic issue_requests();
    for (int i = 0; i < name_q.size(); i++) begin
      v_i <= 1'b1;
      op_i <= op_q[i];
      addr_i <= addr_q[i];
      data_i <= wdata_q[i];
      @(negedge clock_i);
      while (!ready_o) @(negedge clock_i);
      @(posedge clock_i); // Request transfers here
    end
    v_i <= 1'b0;
  endtask

  // Responses taken with a random yumi one cycle after v_o is seen
  task automatic consume_responses();
    logic [w_lp-1:0] exp;
    logic [maw_lp-1:0] widx;
    while (resp_cnt < name_q.size()) begin
      @(negedge clock_i);
      if (yumi_i) begin
        if (!v_o) begin
          $display("Response valid dropped before %s was consumed", name_q[resp_cnt]);
          other_errs++;
        end
        widx = addr_q[resp_cnt][maw_lp-1:0]; // Addresses wrap at the memory size
        if (op_q[resp_cnt] == cache_pkg::STORE) begin
          exp = '0;
          model_mem[widx] = wdata_q[resp_cnt];
        end else begin
          exp = model_mem[widx];
        end
        if (exp !== exp_q[resp_cnt]) begin
          $display("Table entry %s expects %h but the memory model gives %h",
                   name_q[resp_cnt], exp_q[resp_cnt], exp);
          other_errs++;
        end
        compare_word(name_q[resp_cnt], exp, data_o);
        resp_cnt++;
        @(posedge clock_i);
        yumi_i <= 1'b0;
      end else if (v_o && ($random(seed) & 1)) begin
        @(posedge clock_i);
        yumi_i <= 1'b1; // v_o stays high since yumi_i was low
      end
    end
  endtask

  initial begin
    logic [maw_lp-1:0] widx;
    logic extra;
    v_i = 1'b0;
    op_i = cache_pkg::LOAD;
    addr_i = '0;
    data_i = '0;
    yumi_i = 1'b0;
    reset_i = 1'b1;
    extra = 1'b0;

    // Cold misses on first and last words in both banks
    add_entry("cold_b0_first", cache_pkg::LOAD, 32'h010, 32'h0, ~32'h010);
    add_entry("cold_b1_last", cache_pkg::LOAD, 32'h017, 32'h0, ~32'h017);
    add_entry("cold_b0_last", cache_pkg::LOAD, 32'h023, 32'h0, ~32'h023);
    add_entry("cold_b1_first", cache_pkg::LOAD, 32'h024, 32'h0, ~32'h024);
    // Hits on the filled lines
    add_entry("hit_b0_w1", cache_pkg::LOAD, 32'h011, 32'h0, ~32'h011);
    add_entry("hit_b0_w2", cache_pkg::LOAD, 32'h012, 32'h0, ~32'h012);
    add_entry("hit_b0_w3", cache_pkg::LOAD, 32'h013, 32'h0, ~32'h013);
    add_entry("hit_b1_w0", cache_pkg::LOAD, 32'h014, 32'h0, ~32'h014);
    add_entry("hit_b1_w1", cache_pkg::LOAD, 32'h015, 32'h0, ~32'h015);
    add_entry("hit_b1_w2", cache_pkg::LOAD, 32'h016, 32'h0, ~32'h016);
    add_entry("store_hit", cache_pkg::STORE, 32'h012, 32'ha5a5_0012, 32'h0);
    add_entry("load_after_store_hit", cache_pkg::LOAD, 32'h012, 32'h0, 32'ha5a5_0012);
    add_entry("other_bank_same_set", cache_pkg::LOAD, 32'h016, 32'h0, ~32'h016);
    add_entry("store_miss", cache_pkg::STORE, 32'h100, 32'h5a5a_0100, 32'h0);
    add_entry("load_after_store_miss", cache_pkg::LOAD, 32'h100, 32'h0, 32'h5a5a_0100);
    // Same set and bank with tags 0 and 1
    add_entry("conflict_a0", cache_pkg::LOAD, 32'h028, 32'h0, ~32'h028);
    add_entry("conflict_b0", cache_pkg::LOAD, 32'h0a8, 32'h0, ~32'h0a8);
    add_entry("conflict_a1", cache_pkg::LOAD, 32'h029, 32'h0, ~32'h029);
    add_entry("conflict_b1", cache_pkg::LOAD, 32'h0a9, 32'h0, ~32'h0a9);
    add_entry("mixed_store_b0", cache_pkg::STORE, 32'h030, 32'h1234_0030, 32'h0);
    add_entry("mixed_load_b1", cache_pkg::LOAD, 32'h034, 32'h0, ~32'h034);
    add_entry("mixed_load_b0", cache_pkg::LOAD, 32'h030, 32'h0, 32'h1234_0030);
    add_entry("mixed_store_b1", cache_pkg::STORE, 32'h035, 32'h0bad_0035, 32'h0);
    add_entry("mixed_load_b1_hit", cache_pkg::LOAD, 32'h035, 32'h0, 32'h0bad_0035);

    widx = '0;
    repeat (mem_words_lp) begin
      model_mem[widx] = ~w_lp'(widx);
      widx = widx + 1'b1;
    end

    repeat (16) @(posedge clock_i);
    reset_i <= 1'b0;

    fork
      issue_requests();
      consume_responses();
    join

    // Nothing may arrive once every request is answered
    repeat (20) begin
      @(negedge clock_i);
      if (v_o) extra = 1'b1;
    end
    if (extra) begin
      $display("An extra response appeared after all %0d requests were answered",
               name_q.size());
      other_errs++;
    end

    $display("Tests passed %0d failed %0d, other errors %0d", pass_cnt, fail_cnt, other_errs);
    if ((fail_cnt == 0) && (other_errs == 0)) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
src/cache_pkg.sv
src/dma_pkg.sv
src/cache_bank.sv
src/bank_router.sv
src/dram_arbiter.sv
src/mock_dram.sv
src/test_node_client.sv
verif/tb_test_node_client.sv

// ==== Makefile ====
# Verilator simulation of the two-bank cache test node

VERILATOR ?= verilator
TOP ?= tb_test_node_client
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
